// File: design/battle_config.svh
`ifndef BATTLE_CONFIG_SVH
`define BATTLE_CONFIG_SVH

`define H_ACTIVE 10'd640
`define H_FRONT 10'd16
`define H_SYNC 10'd96
`define H_BACK 10'd48
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_ACTIVE 10'd480
`define V_FRONT 10'd10
`define V_SYNC 10'd2
`define V_BACK 10'd33
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define CELL_W 10'd64
`define CELL_H 10'd48
`define GRID_COLS 4'd10
`define GRID_ROWS 4'd10
`define LINE_HALF 10'd2
`define POINTER_HALF 10'd5
`define MASK_X0 6'd8
`define CROSS_HALF 6'd2
`define RING_IN 12'd16
`define RING_OUT 12'd20

`define COLOR_BLACK 12'h000
`define COLOR_SHIP 12'h555
`define COLOR_PLAYER_HIT 12'he91
`define COLOR_MARK 12'hf0c
`define COLOR_GRID 12'h00f
`define COLOR_POINTER 12'hf00

`define ADDR_POINTER_X 8'd100
`define ADDR_POINTER_Y 8'd101

`endif

// File: design/battle_pkg.sv
package battle_pkg;

	// per-cell contents as written by the host
	typedef enum logic [2:0]
	{
		cell_empty      = 3'd0,
		cell_ship       = 3'd1,
		cell_player_hit = 3'd2,
		cell_ai_hit     = 3'd3, // drawn as a ring
		cell_both_hit   = 3'd4  // drawn as a cross
	} cell_state_t;

	// phase of the APB transfer on the bus pins
	typedef enum logic [1:0]
	{
		apb_idle   = 2'd0,
		apb_setup  = 2'd1,
		apb_access = 2'd2
	} apb_phase_t;

endpackage

// File: design/vga_timing.sv
`timescale 1ns/1ns
`include "battle_config.svh"

module vga_timing
(
	input  logic       clk_in,
	input  logic       reset,
	output logic [9:0] pix_x,
	output logic [9:0] pix_y,
	output logic       active,
	output logic       hsync_raw,
	output logic       vsync_raw
);

	localparam logic [9:0] HS_START = `H_ACTIVE + `H_FRONT;
	localparam logic [9:0] HS_END = `H_ACTIVE + `H_FRONT + `H_SYNC;
	localparam logic [9:0] VS_START = `V_ACTIVE + `V_FRONT;
	localparam logic [9:0] VS_END = `V_ACTIVE + `V_FRONT + `V_SYNC;

	always_ff @(posedge clk_in)
	begin
		if (reset)
		begin
			pix_x <= 10'd0;
			pix_y <= 10'd0;
		end
		else if (pix_x == `H_TOTAL - 10'd1) // end of line
		begin
			pix_x <= 10'd0;
			if (pix_y == `V_TOTAL - 10'd1)
				pix_y <= 10'd0;
			else
				pix_y <= pix_y + 10'd1;
		end
		else
		begin
			pix_x <= pix_x + 10'd1;
		end
	end

	assign active = (pix_x < `H_ACTIVE) && (pix_y < `V_ACTIVE);

	// both syncs are active low
	assign hsync_raw = !((pix_x >= HS_START) && (pix_x < HS_END));
	assign vsync_raw = !((pix_y >= VS_START) && (pix_y < VS_END));

endmodule

// File: design/cell_locator.sv
`timescale 1ns/1ns
`include "battle_config.svh"

module cell_locator
(
	input  logic       clk_in,
	input  logic       reset,
	input  logic [9:0] pix_x,
	input  logic [9:0] pix_y,
	input  logic       active,
	output logic [3:0] cell_col,
	output logic [3:0] cell_row,
	output logic [5:0] off_x,
	output logic [5:0] off_y,
	output logic [9:0] px,
	output logic [9:0] py,
	output logic       loc_active
);

	logic [3:0] row_c;
	logic [9:0] base_c;
	logic [9:0] y_rel;

	// rows are 48 high so no shift works here
	always_comb
	begin
		row_c = 4'd0;
		base_c = 10'd0;
		for (int k = 1; k < `GRID_ROWS; k++)
		begin
			if (pix_y >= 10'(k) * `CELL_H)
			begin
				row_c = 4'(k);
				base_c = 10'(k) * `CELL_H;
			end
		end
	end

	assign y_rel = pix_y - base_c; // only low bits matter inside the board

	always_ff @(posedge clk_in)
	begin
		cell_col <= pix_x[9:6]; // 64 wide columns
		cell_row <= row_c;
		off_x <= pix_x[5:0];
		off_y <= y_rel[5:0];
		px <= pix_x;
		py <= pix_y;
	end

	always_ff @(posedge clk_in)
	begin
		if (reset)
			loc_active <= 1'b0;
		else
			loc_active <= active;
	end

endmodule

// File: design/board_regs.sv
`timescale 1ns/1ns
`include "battle_config.svh"

module board_regs
	import battle_pkg::*;
(
	input  logic        clk_in,
	input  logic        reset,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [9:0]  pwdata,
	output logic [9:0]  prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic [3:0]  rd_row,
	input  logic [3:0]  rd_col,
	output cell_state_t cell_state,
	output logic [9:0]  pointer_x,
	output logic [9:0]  pointer_y
);

	localparam int NUM_CELLS = `GRID_COLS * `GRID_ROWS;
	localparam logic [9:0] POINTER_PARK = 10'd700; // off-screen after reset

	cell_state_t cells [NUM_CELLS];
	apb_phase_t  phase;
	apb_phase_t  prev_phase;
	logic        access;
	logic        cell_sel;
	logic        addr_err;
	logic        code_err;
	logic        wr_en;
	logic [6:0]  rd_idx;

	always_comb
	begin
		if (!psel)
			phase = apb_idle;
		else if (!penable)
			phase = apb_setup;
		else
			phase = apb_access;
	end

	always_ff @(posedge clk_in)
	begin
		if (reset)
			prev_phase <= apb_idle;
		else
			prev_phase <= phase;
	end

	// access only counts right after its setup cycle
	assign access = (phase == apb_access) && (prev_phase == apb_setup);
	assign cell_sel = paddr < `ADDR_POINTER_X;
	assign addr_err = paddr > `ADDR_POINTER_Y;
	assign code_err = pwrite && cell_sel && (pwdata > 10'(cell_both_hit));
	assign wr_en = access && pwrite && !addr_err && !code_err;

	assign pready = 1'b1; // zero wait states
	assign pslverr = access && (addr_err || code_err);

	always_comb
	begin
		if (cell_sel)
			prdata = {7'd0, cells[paddr[6:0]]};
		else if (paddr == `ADDR_POINTER_X)
			prdata = pointer_x;
		else if (paddr == `ADDR_POINTER_Y)
			prdata = pointer_y;
		else
			prdata = 10'd0;
	end

	always_ff @(posedge clk_in)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_CELLS; i++)
				cells[i] <= cell_empty;
			pointer_x <= POINTER_PARK;
			pointer_y <= POINTER_PARK;
		end
		else if (wr_en)
		begin
			if (cell_sel)
				cells[paddr[6:0]] <= cell_state_t'(pwdata[2:0]);
			else if (paddr == `ADDR_POINTER_X)
				pointer_x <= pwdata;
			else
				pointer_y <= pwdata;
		end
	end

	// renderer side, index is row*10+col
	assign rd_idx = {3'd0, rd_row} * {3'd0, `GRID_COLS} + {3'd0, rd_col};
	assign cell_state = (rd_idx < 7'(NUM_CELLS)) ? cells[rd_idx] : cell_empty;

endmodule

// File: design/pixel_renderer.sv
`timescale 1ns/1ns
`include "battle_config.svh"

module pixel_renderer
	import battle_pkg::*;
(
	input  logic        clk_in,
	input  logic        reset,
	input  logic [9:0]  px,
	input  logic [9:0]  py,
	input  logic [5:0]  off_x,
	input  logic [5:0]  off_y,
	input  logic        loc_active,
	input  cell_state_t cell_state,
	input  logic [9:0]  pointer_x,
	input  logic [9:0]  pointer_y,
	output logic [11:0] color
);

	localparam logic [5:0] MASK_W = 6'd48;
	localparam logic [5:0] MASK_C = 6'd24; // ring centre
	localparam logic [6:0] ANTI_SUM = 7'd47;

	logic [5:0]  u;
	logic [5:0]  v;
	logic        in_mask;
	logic [5:0]  d_diag;
	logic [6:0]  uv_sum;
	logic [6:0]  d_anti;
	logic [5:0]  dx_c;
	logic [5:0]  dy_c;
	logic [11:0] dist2;
	logic        cross_hit;
	logic        ring_hit;
	logic        v_line;
	logic        h_line;
	logic [9:0]  dx_p;
	logic [9:0]  dy_p;
	logic        ptr_hit;
	logic [11:0] fill;
	logic [11:0] next_color;

	assign u = off_x - `MASK_X0;
	assign v = off_y;
	assign in_mask = (off_x >= `MASK_X0) && (off_x < `MASK_X0 + MASK_W);

	// both diagonals of the mark square
	assign d_diag = (u >= v) ? u - v : v - u;
	assign uv_sum = {1'b0, u} + {1'b0, v};
	assign d_anti = (uv_sum >= ANTI_SUM) ? uv_sum - ANTI_SUM : ANTI_SUM - uv_sum;
	assign cross_hit = in_mask && ((d_diag <= `CROSS_HALF) || (d_anti <= {1'b0, `CROSS_HALF}));

	assign dx_c = (u >= MASK_C) ? u - MASK_C : MASK_C - u;
	assign dy_c = (v >= MASK_C) ? v - MASK_C : MASK_C - v;
	assign dist2 = {6'd0, dx_c} * {6'd0, dx_c} + {6'd0, dy_c} * {6'd0, dy_c};
	assign ring_hit = in_mask && (dist2 >= `RING_IN * `RING_IN)
		&& (dist2 <= `RING_OUT * `RING_OUT);

	// lines are 4 pixels wide, centred just past each border
	always_comb
	begin
		v_line = 1'b0;
		h_line = 1'b0;
		for (int k = 1; k < `GRID_COLS; k++)
		begin
			if ((px + `LINE_HALF > 10'(k) * `CELL_W) && (px <= 10'(k) * `CELL_W + `LINE_HALF))
				v_line = 1'b1;
		end
		for (int k = 1; k < `GRID_ROWS; k++)
		begin
			if ((py + `LINE_HALF > 10'(k) * `CELL_H) && (py <= 10'(k) * `CELL_H + `LINE_HALF))
				h_line = 1'b1;
		end
	end

	assign dx_p = (px >= pointer_x) ? px - pointer_x : pointer_x - px;
	assign dy_p = (py >= pointer_y) ? py - pointer_y : pointer_y - py;
	assign ptr_hit = (dx_p <= `POINTER_HALF) && (dy_p <= `POINTER_HALF);

	always_comb
	begin
		case (cell_state)
			cell_ship:       fill = `COLOR_SHIP;
			cell_player_hit: fill = `COLOR_PLAYER_HIT;
			cell_ai_hit:     fill = ring_hit ? `COLOR_MARK : `COLOR_BLACK;
			cell_both_hit:   fill = cross_hit ? `COLOR_MARK : `COLOR_BLACK;
			default:         fill = `COLOR_BLACK;
		endcase
	end

	always_comb
	begin
		if (!loc_active)
			next_color = `COLOR_BLACK;
		else if (ptr_hit)
			next_color = `COLOR_POINTER; // pointer sits on top of everything
		else if (v_line || h_line)
			next_color = `COLOR_GRID;
		else
			next_color = fill;
	end

	always_ff @(posedge clk_in)
	begin
		if (reset)
			color <= `COLOR_BLACK;
		else
			color <= next_color;
	end

endmodule

// File: design/battle_display.sv
`timescale 1ns/1ns

module battle_display
	import battle_pkg::*;
(
	input  logic        clk_in,
	input  logic        reset,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [9:0]  pwdata,
	output logic [9:0]  prdata,
	output logic        pready,
	output logic        pslverr,
	output logic [11:0] color,
	output logic        hsync,
	output logic        vsync,
	output logic        de
);

	logic [9:0]  pix_x;
	logic [9:0]  pix_y;
	logic        active;
	logic        hsync_raw;
	logic        vsync_raw;
	logic [3:0]  cell_col;
	logic [3:0]  cell_row;
	logic [5:0]  off_x;
	logic [5:0]  off_y;
	logic [9:0]  px;
	logic [9:0]  py;
	logic        loc_active;
	cell_state_t cell_state;
	logic [9:0]  pointer_x;
	logic [9:0]  pointer_y;
	logic [1:0]  hsync_d;
	logic [1:0]  vsync_d;
	logic [1:0]  de_d;

	vga_timing u_timing
	(
		.clk_in(clk_in),
		.reset(reset),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.active(active),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw)
	);

	cell_locator u_locator
	(
		.clk_in(clk_in),
		.reset(reset),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.active(active),
		.cell_col(cell_col),
		.cell_row(cell_row),
		.off_x(off_x),
		.off_y(off_y),
		.px(px),
		.py(py),
		.loc_active(loc_active)
	);

	board_regs u_regs
	(
		.clk_in(clk_in),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.rd_row(cell_row),
		.rd_col(cell_col),
		.cell_state(cell_state),
		.pointer_x(pointer_x),
		.pointer_y(pointer_y)
	);

	pixel_renderer u_renderer
	(
		.clk_in(clk_in),
		.reset(reset),
		.px(px),
		.py(py),
		.off_x(off_x),
		.off_y(off_y),
		.loc_active(loc_active),
		.cell_state(cell_state),
		.pointer_x(pointer_x),
		.pointer_y(pointer_y),
		.color(color)
	);

	// match the locator and renderer stages
	always_ff @(posedge clk_in)
	begin
		if (reset)
		begin
			hsync_d <= 2'b11;
			vsync_d <= 2'b11;
			de_d <= 2'b00;
		end
		else
		begin
			hsync_d <= {hsync_d[0], hsync_raw};
			vsync_d <= {vsync_d[0], vsync_raw};
			de_d <= {de_d[0], active};
		end
	end

	assign hsync = hsync_d[1];
	assign vsync = vsync_d[1];
	assign de = de_d[1];

endmodule

// File: tb/battle_display_assertions.sv
`timescale 1ns/1ns
`include "battle_config.svh"

module battle_display_assertions
	import battle_pkg::*;
(
	input logic        clk_in,
	input logic        reset,
	input logic        psel,
	input logic        penable,
	input logic        pready,
	input logic        pslverr,
	input logic        hsync,
	input logic        vsync,
	input logic        de,
	input logic [11:0] color
);

	apb_phase_t phase;

	always_comb
	begin
		if (!psel)
			phase = apb_idle;
		else if (!penable)
			phase = apb_setup;
		else
			phase = apb_access;
	end

	a_pready: assert property (@(posedge clk_in) disable iff (reset) pready)
		else $error("pready went low");

	a_err_access: assert property (@(posedge clk_in) disable iff (reset)
		pslverr |-> (phase == apb_access))
		else $error("pslverr outside an access cycle");

	a_de_sync: assert property (@(posedge clk_in) disable iff (reset)
		de |-> (hsync && vsync))
		else $error("de high during a sync pulse");

	a_blank_black: assert property (@(posedge clk_in) disable iff (reset)
		!de |-> (color == `COLOR_BLACK))
		else $error("colour not black while de is low");

endmodule

bind battle_display battle_display_assertions u_assertions
(
	.clk_in(clk_in),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.hsync(hsync),
	.vsync(vsync),
	.de(de),
	.color(color)
);

// File: tb/battle_display_tb.sv
`timescale 1ns/1ns
`include "battle_config.svh"

module battle_display_tb
	import battle_pkg::*;
();

	localparam int NUM_TESTS = 8;
	localparam int NUM_PROBES = 3;
	localparam int NUM_RANDOM = 8;
	// one frame is 800 x 525 clocks of 20 ns
	localparam longint WATCHDOG_NS = longint'(NUM_TESTS + 2) * 800 * 525 * 20;

	logic        clk_in;
	logic        reset;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [9:0]  pwdata;
	logic [9:0]  prdata;
	logic        pready;
	logic        pslverr;
	logic [11:0] color;
	logic        hsync;
	logic        vsync;
	logic        de;

	string       t_name [NUM_TESTS];
	logic [7:0]  t_addr [NUM_TESTS];
	logic [9:0]  t_data [NUM_TESTS];
	int          t_ptr_x [NUM_TESTS];
	int          t_ptr_y [NUM_TESTS];
	int          probe_x [NUM_TESTS][NUM_PROBES];
	int          probe_y [NUM_TESTS][NUM_PROBES];
	int          rand_x [NUM_RANDOM];
	int          rand_y [NUM_RANDOM];
	int          seed = 32'hee73_61ad;
	int          entries;
	cell_state_t board [100]; // what the host has written so far
	int          ptr_x;
	int          ptr_y;

	battle_display UUT
	(
		.clk_in(clk_in),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.color(color),
		.hsync(hsync),
		.vsync(vsync),
		.de(de)
	);

	initial
	begin
		clk_in = 1'b0;
		forever
			#10 clk_in = ~clk_in;
	end

	task automatic stop_on_error(input string msg);
		begin
			$display("%s", msg);
			$display("Simulation failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic check_color(input string name, input logic [11:0] exp, input logic [11:0] act);
		begin
			if (act !== exp)
				stop_on_error($sformatf("error: %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_state(input string name, input cell_state_t exp, input cell_state_t act);
		begin
			if (act !== exp)
				stop_on_error($sformatf("error: %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		begin
			if (act !== exp)
				stop_on_error($sformatf("error: %s expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic check_word(input string name, input logic [9:0] exp, input logic [9:0] act);
		begin
			if (act !== exp)
				stop_on_error($sformatf("error: %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	task automatic add_test(input string name, input logic [7:0] addr, input logic [9:0] data,
		input int px, input int py, input int x0, input int y0, input int x1, input int y1,
		input int x2, input int y2);
		begin
			t_name[entries] = name;
			t_addr[entries] = addr;
			t_data[entries] = data;
			t_ptr_x[entries] = px;
			t_ptr_y[entries] = py;
			probe_x[entries] = '{x0, x1, x2};
			probe_y[entries] = '{y0, y1, y2};
			entries++;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [9:0] data, output logic err);
		begin
			@(posedge clk_in);
			#2;
			paddr = addr;
			pwdata = data;
			pwrite = 1'b1;
			psel = 1'b1;
			penable = 1'b0;
			@(posedge clk_in);
			#2;
			penable = 1'b1;
			@(negedge clk_in);
			err = pslverr; // mid access cycle
			@(posedge clk_in);
			#2;
			psel = 1'b0;
			penable = 1'b0;
			pwrite = 1'b0;
		end
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [9:0] data, output logic err);
		begin
			@(posedge clk_in);
			#2;
			paddr = addr;
			pwrite = 1'b0;
			psel = 1'b1;
			penable = 1'b0;
			@(posedge clk_in);
			#2;
			penable = 1'b1;
			@(negedge clk_in);
			data = prdata;
			err = pslverr;
			@(posedge clk_in);
			#2;
			psel = 1'b0;
			penable = 1'b0;
		end
	endtask

	function automatic int abs_diff(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	// grid lines are 4 pixels wide, from 2 before each border to 2 after it
	function automatic logic on_line(input int a, input int size);
		for (int k = 1; k < 10; k++)
		begin
			if (a > k * size - 2 && a <= k * size + 2)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic logic [11:0] expected_color(input int x, input int y);
		int u;
		int v;
		int d2;
		cell_state_t st;
		begin
			u = x % 64 - 8; // mark square starts 8 pixels into the cell
			v = y % 48;
			d2 = (u - 24) * (u - 24) + (v - 24) * (v - 24);
			st = board[(y / 48) * 10 + x / 64];
			if (abs_diff(x, ptr_x) <= 5 && abs_diff(y, ptr_y) <= 5)
				return `COLOR_POINTER;
			if (on_line(x, 64) || on_line(y, 48))
				return `COLOR_GRID;
			case (st)
				cell_ship:       return `COLOR_SHIP;
				cell_player_hit: return `COLOR_PLAYER_HIT;
				cell_ai_hit:
					if (u >= 0 && u < 48 && d2 >= 256 && d2 <= 400)
						return `COLOR_MARK;
				cell_both_hit:
					if (u >= 0 && u < 48 && (abs_diff(u, v) <= 2 || abs_diff(u + v, 47) <= 2))
						return `COLOR_MARK;
				default: ;
			endcase
			return `COLOR_BLACK;
		end
	endfunction

	task automatic apply_writes(input int t);
		logic       err;
		logic       exp_err;
		logic [9:0] rd;
		begin
			// codes 5 to 7 are invalid, addresses above 101 do not exist
			exp_err = (t_addr[t] > `ADDR_POINTER_Y)
				|| (t_addr[t] < `ADDR_POINTER_X && t_data[t] > 10'd4);
			// pointer goes first so a stray write to it shows up
			apb_write(`ADDR_POINTER_X, 10'(t_ptr_x[t]), err);
			check_err({t_name[t], " pointer x pslverr"}, 1'b0, err);
			ptr_x = t_ptr_x[t];
			apb_write(`ADDR_POINTER_Y, 10'(t_ptr_y[t]), err);
			check_err({t_name[t], " pointer y pslverr"}, 1'b0, err);
			ptr_y = t_ptr_y[t];
			apb_write(t_addr[t], t_data[t], err);
			check_err({t_name[t], " write pslverr"}, exp_err, err);
			if (!exp_err && t_addr[t] < `ADDR_POINTER_X)
				board[t_addr[t]] = cell_state_t'(t_data[t][2:0]);
			apb_read(t_addr[t], rd, err);
			check_err({t_name[t], " read pslverr"}, t_addr[t] > `ADDR_POINTER_Y, err);
			if (t_addr[t] < `ADDR_POINTER_X)
			begin
				check_state({t_name[t], " read back"}, board[t_addr[t]], cell_state_t'(rd[2:0]));
				check_word({t_name[t], " read upper bits"}, 10'd0, rd & 10'h3f8);
			end
			apb_read(`ADDR_POINTER_X, rd, err);
			check_word({t_name[t], " pointer x read"}, 10'(ptr_x), rd);
			apb_read(`ADDR_POINTER_Y, rd, err);
			check_word({t_name[t], " pointer y read"}, 10'(ptr_y), rd);
		end
	endtask

	task automatic check_probe(input int t, input int x, input int y);
		logic hit;
		begin
			hit = 1'b0;
			for (int p = 0; p < NUM_PROBES; p++)
			begin
				if (probe_x[t][p] == x && probe_y[t][p] == y)
					hit = 1'b1;
			end
			for (int r = 0; r < NUM_RANDOM; r++)
			begin
				if (rand_x[r] == x && rand_y[r] == y)
					hit = 1'b1;
			end
			if (hit)
				check_color($sformatf("%s pixel (%0d,%0d)", t_name[t], x, y),
					expected_color(x, y), color);
		end
	endtask

	// x and y follow de from the end of vsync to the start of the next one
	task automatic scan_frame(input int t);
		int   x;
		int   y;
		int   pos;
		int   hs_lines;
		logic seen;
		logic de_prev;
		logic hs_prev;
		logic vs_prev;
		logic done;
		begin
			while (vsync !== 1'b1)
				@(negedge clk_in);
			x = 0;
			y = 0;
			pos = 0;
			hs_lines = 0;
			seen = 1'b0;
			done = 1'b0;
			de_prev = 1'b0;
			hs_prev = hsync;
			vs_prev = 1'b1;
			while (!done)
			begin
				@(negedge clk_in);
				if (de && !de_prev)
				begin
					pos = 0;
					seen = 1'b1;
				end
				else
					pos++;
				if (!hsync && hs_prev && seen)
				begin
					check_word($sformatf("%s hsync line %0d", t_name[t], y - 1), 10'd656, 10'(pos));
					hs_lines++;
					seen = 1'b0;
				end
				if (de)
				begin
					check_probe(t, x, y);
					x++;
				end
				else if (de_prev)
				begin
					check_word($sformatf("%s width line %0d", t_name[t], y), 10'd640, 10'(x));
					x = 0;
					y++;
				end
				done = !vsync && vs_prev;
				de_prev = de;
				hs_prev = hsync;
				vs_prev = vsync;
			end
			check_word({t_name[t], " de lines"}, 10'd480, 10'(y));
			check_word({t_name[t], " hsync pulses"}, 10'd480, 10'(hs_lines));
		end
	endtask

	initial
	begin
		reset = 1'b1;
		paddr = 8'd0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = 10'd0;
		ptr_x = 700; // pointer parks off-screen after reset
		ptr_y = 700;
		entries = 0;
		for (int i = 0; i < 100; i++)
			board[i] = cell_empty;
		add_test("empty_board", 8'd0, 10'd0, 700, 700, 30, 20, 64, 100, 200, 48);
		add_test("ship_fill", 8'd12, 10'd1, 700, 700, 150, 70, 190, 94, 129, 60);
		add_test("player_hit", 8'd33, 10'd2, 220, 160, 220, 160, 250, 185, 192, 150);
		add_test("ai_ring", 8'd45, 10'd3, 700, 700, 352, 216, 370, 216, 352, 236);
		add_test("both_cross", 8'd56, 10'd4, 700, 700, 416, 264, 400, 250, 425, 250);
		add_test("bad_code_5", 8'd12, 10'd5, 700, 700, 150, 70, 160, 60, 129, 60);
		add_test("bad_code_7", 8'd33, 10'd7, 700, 700, 250, 185, 220, 160, 200, 170);
		add_test("bad_addr", 8'd120, 10'd3, 128, 96, 128, 96, 133, 101, 134, 96);
		repeat (4)
			@(posedge clk_in);
		#2;
		reset = 1'b0;
		while (vsync !== 1'b0) // first vertical blanking
			@(negedge clk_in);
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			apply_writes(t);
			for (int r = 0; r < NUM_RANDOM; r++)
			begin
				rand_x[r] = ($random(seed) & 32'h7fff_ffff) % 640;
				rand_y[r] = ($random(seed) & 32'h7fff_ffff) % 480;
			end
			scan_frame(t);
		end
		$display("Simulation completed successfully");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		stop_on_error("timeout: the video frames did not all finish before the watchdog ran out");
	end

endmodule

// File: project.f
+incdir+design
design/battle_pkg.sv
design/vga_timing.sv
design/cell_locator.sv
design/board_regs.sv
design/pixel_renderer.sv
design/battle_display.sv
tb/battle_display_assertions.sv
tb/battle_display_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the battle display testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
	-f project.f --top-module battle_display_tb -o sim_battle

status=0
./obj_dir/sim_battle 2>&1 | tee sim.log || status=$?

if grep -q "Simulation failed" sim.log || [ "$status" -ne 0 ] \
	|| ! grep -q "Simulation completed successfully" sim.log; then
	echo "run_sim: test run FAILED, see sim.log"
	exit 1
fi
echo "run_sim: test run passed"
